// ==== hdl/arcade_input_pkg.sv ====
`default_nettype none

package arcade_input_pkg;

	// ======================================================================
	// DB15 serial pad link
	// ======================================================================
	localparam int PAD_BITS          = 16;
	localparam int DB15_FRAME_BITS   = 32; // Player 1 bits first
	localparam int DB15_DIV_BITS     = 3;  // 8 clocks per pad bit
	localparam int DB15_SAMPLE_PHASE = (1 << (DB15_DIV_BITS - 1)) - 1; // Last low cycle

	// ======================================================================
	// Rotary dial
	// ======================================================================
	localparam int ROT_POSITIONS = 12;
	localparam int ROT_RESET_POS = 11;

	typedef enum logic [1:0] {
		ROT_NORMAL    = 2'd0,
		ROT_SLOW      = 2'd1, // Same period as normal here
		ROT_FAST      = 2'd2,
		ROT_VERY_FAST = 2'd3
	} rot_speed_t;

	// Download stream targets
	localparam int DIP_INDEX  = 254;
	localparam int GAME_INDEX = 1;
	localparam int DIP_BYTES  = 8;

	// Player word layout, active low
	localparam int PLAYER_BITS = 16;
	localparam int PW_COIN     = 0;
	localparam int PW_START    = 1;
	localparam int PW_SHOT     = 2;
	localparam int PW_MISSILE  = 3;
	localparam int PW_ROT_LSB  = 4;  // 4-bit dial field
	localparam int PW_FIXED    = 8;  // Tied high
	localparam int PW_SERVICE  = 9;
	localparam int PW_LEFT     = 10;
	localparam int PW_RIGHT    = 11;
	localparam int PW_DOWN     = 12;
	localparam int PW_UP       = 13;

	// Raw DB15 pad bits, active low
	localparam int DB_RIGHT  = 0;
	localparam int DB_LEFT   = 1;
	localparam int DB_DOWN   = 2;
	localparam int DB_UP     = 3;
	localparam int DB_A      = 4;
	localparam int DB_B      = 5;
	localparam int DB_C      = 6;
	localparam int DB_D      = 7;
	localparam int DB_START  = 10;
	localparam int DB_SELECT = 11;

	// Host joystick bits, active high
	localparam int HJ_RIGHT     = 0;
	localparam int HJ_LEFT      = 1;
	localparam int HJ_DOWN      = 2;
	localparam int HJ_UP        = 3;
	localparam int HJ_SHOT      = 4;
	localparam int HJ_MISSILE   = 5;
	localparam int HJ_START     = 6;
	localparam int HJ_COIN      = 7;
	localparam int HJ_ROT_LEFT  = 8;
	localparam int HJ_ROT_RIGHT = 9;
	localparam int HJ_SERVICE   = 10;

endpackage

`default_nettype wire

// ==== hdl/db15_serial_reader.sv ====
`default_nettype none

module db15_serial_reader (
	input  wire                                    clk_53p6,
	input  wire                                    rst_n,
	input  wire                                    joy_data,  // Shared serial line
	output logic                                   joy_load,
	output logic                                   joy_clk,
	output logic [arcade_input_pkg::PAD_BITS-1:0]  pad_1,
	output logic [arcade_input_pkg::PAD_BITS-1:0]  pad_2
);

	// ======================================================================
	// Bit period and frame counters
	// ======================================================================
	logic [arcade_input_pkg::DB15_DIV_BITS-1:0]                    div_cnt;
	logic [arcade_input_pkg::DB15_DIV_BITS-1:0]                    div_nxt;
	logic [$clog2(arcade_input_pkg::DB15_FRAME_BITS + 1)-1:0]      bit_cnt; // 0 is load period
	logic [$clog2(arcade_input_pkg::DB15_FRAME_BITS + 1)-1:0]      bit_nxt;
	logic [arcade_input_pkg::DB15_FRAME_BITS-1:0]                  shift_q;
	logic [arcade_input_pkg::DB15_FRAME_BITS-1:0]                  shift_nxt;
	logic                                                          sample_en;
	logic                                                          frame_done;

	always_comb begin
		div_nxt = div_cnt + 1'b1; // Wraps at end of bit period
		bit_nxt = bit_cnt;
		if (&div_cnt) begin
			if (bit_cnt == arcade_input_pkg::DB15_FRAME_BITS)
				bit_nxt = '0; // Next frame starts right away
			else
				bit_nxt = bit_cnt + 1'b1;
		end
	end

	// Sample on the last cycle before joy_clk rises
	assign sample_en  = (bit_cnt != '0) &&
		(div_cnt == arcade_input_pkg::DB15_DIV_BITS'(arcade_input_pkg::DB15_SAMPLE_PHASE));
	assign frame_done = sample_en && (bit_cnt == arcade_input_pkg::DB15_FRAME_BITS);
	assign shift_nxt  = {joy_data, shift_q[arcade_input_pkg::DB15_FRAME_BITS-1:1]}; // LSB first

	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			div_cnt  <= '0;
			bit_cnt  <= '0;
			joy_load <= 1'b0;
			joy_clk  <= 1'b0;
			pad_1    <= '1; // Released
			pad_2    <= '1;
		end else begin
			div_cnt  <= div_nxt;
			bit_cnt  <= bit_nxt;
			// Outputs follow the counters' next state so they line up with them
			joy_load <= (bit_nxt == '0);
			joy_clk  <= (bit_nxt != '0) && div_nxt[arcade_input_pkg::DB15_DIV_BITS-1];
			if (frame_done) begin
				pad_1 <= shift_nxt[arcade_input_pkg::PAD_BITS-1:0];
				pad_2 <= shift_nxt[arcade_input_pkg::DB15_FRAME_BITS-1:arcade_input_pkg::PAD_BITS];
			end
		end
	end

	// Sample collector
	always_ff @(posedge clk_53p6) begin
		if (sample_en)
			shift_q <= shift_nxt;
	end

	// Pad shift register would see a clock during parallel load
	a_load_clk_excl: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		!(joy_load && joy_clk));

endmodule

`default_nettype wire

// ==== hdl/control_mapper.sv ====
`default_nettype none

module control_mapper (
	input  wire                                       db15_sel,  // 1 = DB15 pad
	input  wire  [arcade_input_pkg::PAD_BITS-1:0]     pad,       // Active low
	input  wire  [15:0]                               host_joy,  // Active high
	input  wire  [3:0]                                rot_pos,
	output logic                                      rot_left,
	output logic                                      rot_right,
	output logic [arcade_input_pkg::PLAYER_BITS-1:0]  player     // Active low
);

	always_comb begin
		player = '1; // Bits 15, 14 and fixed bit stay high
		player[arcade_input_pkg::PW_ROT_LSB +: 4] = rot_pos;

		if (db15_sel) begin
			// ==============================================================
			// DB15 pad, already active low
			// ==============================================================
			player[arcade_input_pkg::PW_UP]      = pad[arcade_input_pkg::DB_UP];
			player[arcade_input_pkg::PW_DOWN]    = pad[arcade_input_pkg::DB_DOWN];
			player[arcade_input_pkg::PW_LEFT]    = pad[arcade_input_pkg::DB_LEFT];
			player[arcade_input_pkg::PW_RIGHT]   = pad[arcade_input_pkg::DB_RIGHT];
			player[arcade_input_pkg::PW_SHOT]    = pad[arcade_input_pkg::DB_B];
			player[arcade_input_pkg::PW_MISSILE] = pad[arcade_input_pkg::DB_C];
			player[arcade_input_pkg::PW_START]   = pad[arcade_input_pkg::DB_START];
			player[arcade_input_pkg::PW_COIN]    = pad[arcade_input_pkg::DB_SELECT];
			// Service combo is B held with Select
			player[arcade_input_pkg::PW_SERVICE] = pad[arcade_input_pkg::DB_B] |
				pad[arcade_input_pkg::DB_SELECT];
			rot_left  = ~pad[arcade_input_pkg::DB_A];
			rot_right = ~pad[arcade_input_pkg::DB_D];
		end else begin
			// ==============================================================
			// Host joystick, invert to active low
			// ==============================================================
			player[arcade_input_pkg::PW_UP]      = ~host_joy[arcade_input_pkg::HJ_UP];
			player[arcade_input_pkg::PW_DOWN]    = ~host_joy[arcade_input_pkg::HJ_DOWN];
			player[arcade_input_pkg::PW_LEFT]    = ~host_joy[arcade_input_pkg::HJ_LEFT];
			player[arcade_input_pkg::PW_RIGHT]   = ~host_joy[arcade_input_pkg::HJ_RIGHT];
			player[arcade_input_pkg::PW_SHOT]    = ~host_joy[arcade_input_pkg::HJ_SHOT];
			player[arcade_input_pkg::PW_MISSILE] = ~host_joy[arcade_input_pkg::HJ_MISSILE];
			player[arcade_input_pkg::PW_START]   = ~host_joy[arcade_input_pkg::HJ_START];
			player[arcade_input_pkg::PW_COIN]    = ~host_joy[arcade_input_pkg::HJ_COIN];
			player[arcade_input_pkg::PW_SERVICE] = ~host_joy[arcade_input_pkg::HJ_SERVICE];
			rot_left  = host_joy[arcade_input_pkg::HJ_ROT_LEFT];  // Stays active high
			rot_right = host_joy[arcade_input_pkg::HJ_ROT_RIGHT];
		end
	end

endmodule

`default_nettype wire

// ==== hdl/rotary_stepper.sv ====
`default_nettype none

module rotary_stepper #(
	parameter int tick_div_bits = 23 // Full tick period is 2**tick_div_bits
) (
	input  wire                            clk_53p6,
	input  wire                            rst_n,
	input  var arcade_input_pkg::rot_speed_t rot_speed,
	input  wire                            rot_left_1,
	input  wire                            rot_right_1,
	input  wire                            rot_left_2,
	input  wire                            rot_right_2,
	output logic [3:0]                     rot_pos_1,
	output logic [3:0]                     rot_pos_2
);

	logic [tick_div_bits-1:0] div_cnt; // Shared by both players
	logic                     tick;

	// One dial step, left wins over right
	function automatic logic [3:0] step_pos(input logic [3:0] pos, input logic left,
		input logic right);
		logic [3:0] nxt;
		nxt = pos;
		if (left)
			nxt = (pos == 4'(arcade_input_pkg::ROT_POSITIONS - 1)) ? 4'd0 : pos + 4'd1;
		else if (right)
			nxt = (pos == 4'd0) ? 4'(arcade_input_pkg::ROT_POSITIONS - 1) : pos - 4'd1;
		return nxt;
	endfunction

	// ======================================================================
	// Speed dependent tick decode
	// ======================================================================
	always_comb begin
		case (rot_speed)
			arcade_input_pkg::ROT_NORMAL:    tick = ~|div_cnt;
			arcade_input_pkg::ROT_SLOW:      tick = ~|div_cnt;
			arcade_input_pkg::ROT_FAST:      tick = ~|div_cnt[tick_div_bits-2:0]; // Half period
			arcade_input_pkg::ROT_VERY_FAST: tick = ~|div_cnt[tick_div_bits-3:0]; // Quarter
			default:                         tick = ~|div_cnt;
		endcase
	end

	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			div_cnt   <= '0; // Tick on first cycle out of reset
			rot_pos_1 <= 4'(arcade_input_pkg::ROT_RESET_POS);
			rot_pos_2 <= 4'(arcade_input_pkg::ROT_RESET_POS);
		end else begin
			div_cnt <= div_cnt + 1'b1; // Free running
			if (tick) begin
				rot_pos_1 <= step_pos(rot_pos_1, rot_left_1, rot_right_1);
				rot_pos_2 <= step_pos(rot_pos_2, rot_left_2, rot_right_2);
			end
		end
	end

	// Game decodes only 12 dial positions
	a_pos_range: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		(rot_pos_1 < arcade_input_pkg::ROT_POSITIONS) &&
		(rot_pos_2 < arcade_input_pkg::ROT_POSITIONS));

endmodule

`default_nettype wire

// ==== hdl/dip_switch_bank.sv ====
`default_nettype none

module dip_switch_bank (
	input  wire         clk_53p6,
	input  wire         rst_n,
	input  wire         dl_wr,     // One cycle per byte
	input  wire  [7:0]  dl_index,
	input  wire  [24:0] dl_addr,
	input  wire  [7:0]  dl_data,
	output logic [15:0] dsw,       // sw[1] high, sw[0] low
	output logic [7:0]  game
);

	logic [7:0] sw [arcade_input_pkg::DIP_BYTES]; // Full DIP bank as downloaded
	logic       dip_wr;
	logic       game_wr;

	assign dip_wr  = dl_wr && (dl_index == 8'(arcade_input_pkg::DIP_INDEX)) &&
		(dl_addr < 25'(arcade_input_pkg::DIP_BYTES)); // Past the bank is dropped
	assign game_wr = dl_wr && (dl_index == 8'(arcade_input_pkg::GAME_INDEX)) &&
		(dl_addr == '0);

	always_ff @(posedge clk_53p6) begin
		if (!rst_n) begin
			for (int i = 0; i < arcade_input_pkg::DIP_BYTES; i++)
				sw[i] <= '0;
			game <= '0;
		end else begin
			if (dip_wr)
				sw[dl_addr[$clog2(arcade_input_pkg::DIP_BYTES)-1:0]] <= dl_data;
			if (game_wr)
				game <= dl_data; // Selects the board variant
		end
	end

	assign dsw = {sw[1], sw[0]}; // Board reads only two banks

	// Byte 0 lands on dsw one cycle after its write
	a_dsw_low: assert property (@(posedge clk_53p6) disable iff (!rst_n)
		(dl_wr && (dl_index == 8'(arcade_input_pkg::DIP_INDEX)) && (dl_addr == '0))
		|=> (dsw[7:0] == $past(dl_data)));

endmodule

`default_nettype wire

// ==== hdl/arcade_input_top.sv ====
`default_nettype none

module arcade_input_top #(
	parameter int tick_div_bits = 23
) (
	input  wire                                       clk_53p6,
	input  wire                                       rst_n,
	// DB15 pad link
	output logic                                      joy_load,
	output logic                                      joy_clk,
	input  wire                                       joy_data,
	// Host side controls
	input  wire  [15:0]                               host_joy_1,
	input  wire  [15:0]                               host_joy_2,
	input  wire  [1:0]                                db15_en,   // Bit per player
	input  var arcade_input_pkg::rot_speed_t          rot_speed,
	// Download stream
	input  wire                                       dl_wr,
	input  wire  [7:0]                                dl_index,
	input  wire  [24:0]                               dl_addr,
	input  wire  [7:0]                                dl_data,
	// To game board
	output logic [arcade_input_pkg::PLAYER_BITS-1:0]  player_1,
	output logic [arcade_input_pkg::PLAYER_BITS-1:0]  player_2,
	output logic [15:0]                               dsw,
	output logic [7:0]                                game
);

	logic [arcade_input_pkg::PAD_BITS-1:0] pad_1;
	logic [arcade_input_pkg::PAD_BITS-1:0] pad_2;
	logic                                  rot_left_1;
	logic                                  rot_right_1;
	logic                                  rot_left_2;
	logic                                  rot_right_2;
	logic [3:0]                            rot_pos_1;
	logic [3:0]                            rot_pos_2;

	// ======================================================================
	// Pad reader, mappers, dial and DIP bank
	// ======================================================================
	db15_serial_reader db15_serial_reader_i (
		.clk_53p6(clk_53p6), .rst_n(rst_n), .joy_data(joy_data),
		.joy_load(joy_load), .joy_clk(joy_clk), .pad_1(pad_1), .pad_2(pad_2)
	);

	control_mapper control_mapper_1_i (
		.db15_sel(db15_en[0]), .pad(pad_1), .host_joy(host_joy_1), .rot_pos(rot_pos_1),
		.rot_left(rot_left_1), .rot_right(rot_right_1), .player(player_1)
	);

	control_mapper control_mapper_2_i (
		.db15_sel(db15_en[1]), .pad(pad_2), .host_joy(host_joy_2), .rot_pos(rot_pos_2),
		.rot_left(rot_left_2), .rot_right(rot_right_2), .player(player_2)
	);

	rotary_stepper #(.tick_div_bits(tick_div_bits)) rotary_stepper_i (
		.clk_53p6(clk_53p6), .rst_n(rst_n), .rot_speed(rot_speed),
		.rot_left_1(rot_left_1), .rot_right_1(rot_right_1),
		.rot_left_2(rot_left_2), .rot_right_2(rot_right_2),
		.rot_pos_1(rot_pos_1), .rot_pos_2(rot_pos_2)
	);

	dip_switch_bank dip_switch_bank_i (
		.clk_53p6(clk_53p6), .rst_n(rst_n), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .dsw(dsw), .game(game)
	);

endmodule

`default_nettype wire

// ==== verification/db15_pad_model.sv ====
`default_nettype none

module db15_pad_model (
	input  wire        joy_load,
	input  wire        joy_clk,
	input  wire [15:0] pad_word_1,  // Raw pad state, active low
	input  wire [15:0] pad_word_2,
	output logic       joy_data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] frame = '1;   // Player 1 in the low half
	int          bit_idx = 0;  // Bit now on the line

	// Parallel load latches both pads and presents bit 0
	always @(posedge joy_load) begin
		frame   = {pad_word_2, pad_word_1};
		bit_idx = 0;
	end

	// One bit further on each shift clock
	always @(posedge joy_clk) begin
		if (bit_idx < 31)
			bit_idx = bit_idx + 1;
	end

	assign joy_data = frame[bit_idx];

endmodule

`default_nettype wire

// ==== verification/arcade_input_tb.sv ====
`default_nettype none

module arcade_input_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICK_DIV_BITS = 8;
	localparam int TIMEOUT       = 1000;   // Cycles allowed per wait
	localparam int FRAME_CYCLES  = 33 * 8; // Load period and 32 data bits, 8 clocks each
	localparam int FRAME_CLOCKS  = 32;     // joy_clk pulses per frame

	logic                         clk_53p6;
	logic                         rst_n;
	logic [15:0]                  host_joy_1;
	logic [15:0]                  host_joy_2;
	logic [1:0]                   db15_en;
	arcade_input_pkg::rot_speed_t rot_speed;
	logic                         dl_wr;
	logic [7:0]                   dl_index;
	logic [24:0]                  dl_addr;
	logic [7:0]                   dl_data;
	logic [15:0]                  pad_word_1; // Raw, active low
	logic [15:0]                  pad_word_2;
	wire                          joy_load;
	wire                          joy_clk;
	wire                          joy_data;
	wire  [15:0]                  player_1;
	wire  [15:0]                  player_2;
	wire  [15:0]                  dsw;
	wire  [7:0]                   game;

	arcade_input_top #(.tick_div_bits(TICK_DIV_BITS)) arcade_input_top_i (
		.clk_53p6(clk_53p6), .rst_n(rst_n), .joy_load(joy_load), .joy_clk(joy_clk),
		.joy_data(joy_data), .host_joy_1(host_joy_1), .host_joy_2(host_joy_2),
		.db15_en(db15_en), .rot_speed(rot_speed), .dl_wr(dl_wr), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data), .player_1(player_1), .player_2(player_2),
		.dsw(dsw), .game(game)
	);

	db15_pad_model db15_pad_model_i (
		.joy_load(joy_load), .joy_clk(joy_clk), .pad_word_1(pad_word_1),
		.pad_word_2(pad_word_2), .joy_data(joy_data)
	);

	initial begin
		clk_53p6 = 1'b0;
		forever #10 clk_53p6 = ~clk_53p6; // 20 ns period
	end

	// ======================================================================
	// Helpers and expected player words
	// ======================================================================
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("TEST FAIL");
			$display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
			$fatal(1);
		end
	endtask

	task automatic timed_out(input string what);
		$display("TEST FAIL");
		$display("Timed out waiting for %s", what);
		$fatal(1);
	endtask

	task automatic next_drive_slot();
		@(posedge clk_53p6);
		#2; // Clear of the edge
	endtask

	// Counts rising edges of the pad load pulse, checks frame length and clocks
	task automatic wait_pad_frames(input int loads);
		logic prev_load;
		logic prev_clk;
		int   seen;
		int   waited;
		int   since;
		int   clks;
		prev_load = joy_load;
		prev_clk  = joy_clk;
		seen      = 0;
		waited    = 0;
		since     = 0;
		clks      = 0;
		while (seen < loads) begin
			@(negedge clk_53p6);
			since++;
			if (joy_clk && !prev_clk)
				clks++;
			if (joy_load && !prev_load) begin
				if (seen > 0) begin // Whole frame seen since last load
					check("joy_load period", since, FRAME_CYCLES);
					check("joy_clk pulses", clks, FRAME_CLOCKS);
				end
				seen++;
				since = 0;
				clks  = 0;
			end
			prev_load = joy_load;
			prev_clk  = joy_clk;
			waited++;
			if (waited > TIMEOUT * loads)
				timed_out("pad load pulse");
		end
	endtask

	// Bits 15 to 0 are 1 1 up down right left service 1 dial[3:0] missile shot start coin
	function automatic logic [15:0] host_word(input logic [15:0] h, input logic [3:0] pos);
		return {2'b11, ~h[3], ~h[2], ~h[0], ~h[1], ~h[10], 1'b1, pos,
			~h[5], ~h[4], ~h[6], ~h[7]};
	endfunction

	function automatic logic [15:0] db15_word(input logic [15:0] p, input logic [3:0] pos);
		return {2'b11, p[3], p[2], p[0], p[1], p[5] | p[11], 1'b1, pos,
			p[6], p[5], p[10], p[11]}; // Service needs B and Select both low
	endfunction

	// ======================================================================
	// Directed tests
	// ======================================================================
	task automatic test_reset_state();
		@(negedge clk_53p6);
		check("player_1", player_1, 16'hFFBF); // Dial parked at 11
		check("player_2", player_2, 16'hFFBF);
		check("dsw", dsw, 16'h0000);
		check("game", game, 8'h00);
	endtask

	task automatic test_host_map();
		for (int i = 0; i < 8; i++) begin
			next_drive_slot();
			host_joy_1 = 16'($urandom) & 16'hFCFF; // No rotation bits
			host_joy_2 = 16'($urandom) & 16'hFCFF;
			@(negedge clk_53p6);
			check("player_1", player_1, host_word(host_joy_1, 4'd11));
			check("player_2", player_2, host_word(host_joy_2, 4'd11));
		end
	endtask

	task automatic test_db15_map();
		logic [15:0] p1;
		logic [15:0] p2;
		for (int round = 0; round < 3; round++) begin
			p1 = 16'($urandom) | 16'h0090; // A and D released
			p2 = 16'($urandom) | 16'h0090;
			if (round == 2)
				p1 = p1 & 16'hF7DF; // Service combo held on pad 1
			next_drive_slot();
			pad_word_1 = p1;
			pad_word_2 = p2;
			db15_en    = 2'b11;
			wait_pad_frames(2);
			check("player_1", player_1, db15_word(p1, 4'd11));
			check("player_2", player_2, db15_word(p2, 4'd11));
		end
		next_drive_slot();
		db15_en = 2'b01; // Player 2 back on host
		@(negedge clk_53p6);
		check("player_1", player_1, db15_word(p1, 4'd11));
		check("player_2", player_2, host_word(host_joy_2, 4'd11));
		next_drive_slot();
		db15_en = 2'b10;
		@(negedge clk_53p6);
		check("player_1", player_1, host_word(host_joy_1, 4'd11));
		check("player_2", player_2, db15_word(p2, 4'd11));
		next_drive_slot();
		db15_en = 2'b00;
	endtask

	// Holds one rotate control and follows the dial through 13 steps
	task automatic spin_dial(input logic second, input arcade_input_pkg::rot_speed_t speed);
		logic [3:0] pos;
		logic [3:0] now;
		logic [3:0] want;
		int         period;
		int         changes;
		int         waited;
		period  = (speed == arcade_input_pkg::ROT_FAST) ? (1 << (TICK_DIV_BITS - 1)) :
			(1 << (TICK_DIV_BITS - 2));
		pos     = 4'd11;
		changes = 0;
		waited  = 0;
		next_drive_slot();
		rot_speed  = speed;
		host_joy_1 = second ? 16'h0000 : 16'h0100; // Rotate left
		host_joy_2 = second ? 16'h0200 : 16'h0000; // Rotate right
		while (changes < 13) begin
			@(negedge clk_53p6);
			waited++;
			now = second ? player_2[7:4] : player_1[7:4];
			if (now != pos) begin
				if (second)
					want = (pos == 4'd0) ? 4'd11 : pos - 4'd1;
				else
					want = (pos == 4'd11) ? 4'd0 : pos + 4'd1;
				check(second ? "player_2[7:4]" : "player_1[7:4]", now, want);
				if (changes > 0)
					check("tick period", waited, period);
				pos    = now;
				waited = 0;
				changes++;
			end else if (waited > TIMEOUT) begin
				timed_out("dial step");
			end
		end
		next_drive_slot();
		host_joy_1 = '0;
		host_joy_2 = '0;
	endtask

	task automatic test_download();
		logic [7:0]  sw0;
		logic [7:0]  sw1;
		logic [7:0]  gm;
		logic [7:0]  data;
		logic [24:0] addr;
		logic        dip;
		sw0 = '0;
		sw1 = '0;
		gm  = '0;
		for (int i = 0; i < 40; i++) begin
			dip  = ($urandom % 4) != 0;
			addr = dip ? 25'($urandom % 10) : '0; // 8 and 9 fall past the bank
			data = 8'($urandom);
			next_drive_slot();
			dl_wr    = 1'b1;
			dl_index = dip ? 8'd254 : 8'd1;
			dl_addr  = addr;
			dl_data  = data;
			next_drive_slot();
			dl_wr = 1'b0;
			if (dip && addr == 25'd0)
				sw0 = data;
			if (dip && addr == 25'd1)
				sw1 = data;
			if (!dip)
				gm = data;
			@(negedge clk_53p6);
			check("dsw", dsw, {sw1, sw0});
			check("game", game, gm);
		end
	endtask

	initial begin
		void'($urandom(61474));
		rst_n      = 1'b0;
		host_joy_1 = '0;
		host_joy_2 = '0;
		db15_en    = 2'b00;
		rot_speed  = arcade_input_pkg::ROT_NORMAL;
		dl_wr      = 1'b0;
		dl_index   = '0;
		dl_addr    = '0;
		dl_data    = '0;
		pad_word_1 = '1; // Pads released
		pad_word_2 = '1;
		repeat (5) @(posedge clk_53p6);
		#2;
		rst_n = 1'b1;
		test_reset_state();
		test_host_map();
		test_db15_map();
		spin_dial(1'b0, arcade_input_pkg::ROT_FAST);
		spin_dial(1'b1, arcade_input_pkg::ROT_VERY_FAST);
		test_download();
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/arcade_input_pkg.sv
hdl/db15_serial_reader.sv
hdl/control_mapper.sv
hdl/rotary_stepper.sv
hdl/dip_switch_bank.sv
hdl/arcade_input_top.sv
verification/db15_pad_model.sv
verification/arcade_input_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := arcade_input_tb
RTL_TOP    := arcade_input_top
FILELIST   := files.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
